//--- branch_predictor_top.f
+incdir+hdl
hdl/bp_pkg.sv
hdl/bp_table.sv
hdl/bp_clear_counter.sv
hdl/bp_update.sv
hdl/bp_control.sv
hdl/branch_predictor_top.sv
testbench/branch_predictor_assertions.sv
testbench/branch_predictor_tb.sv

//--- hdl/bp_clear_counter.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_clear_counter import bp_pkg::*; (
	input logic clk,
	input logic rst,
	input logic en,
	output index_t index,
	output logic done
);

	localparam index_t last_index = index_t'(`BP_TABLE_SIZE - 1);

	// ############################################################
	// sweep counter
	// ############################################################

	// one entry per cycle, stops on the last one
	always_ff @(posedge clk) begin
		if (rst) begin
			index <= '0;
			done <= 1'b0;
		end else if (en && !done) begin
			if (index == last_index) begin
				done <= 1'b1; // sticky until next reset
			end else begin
				index <= index_t'(index + 1'b1);
			end
		end
	end

endmodule

//--- hdl/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// ############################################################
// table geometry
// ############################################################

`define BP_TABLE_SIZE 256 // direct mapped, one way
`define BP_INDEX_BITS 8 // low ip bits
`define BP_TAG_BITS 56 // high ip bits

// ############################################################
// bus and counter
// ############################################################

`define BP_WB_ADDR_BITS 3 // word address
`define BP_CTR_RESET 2'b10 // weakly taken

`endif

//--- hdl/bp_control.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_control import bp_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [`BP_WB_ADDR_BITS-1:0] adr,
	input logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic ack,
	input logic clear_done,
	output logic clear_en,
	input logic pred_taken,
	input logic pred_hit,
	output logic [63:0] lookup_ip,
	output logic [63:0] recent_ip,
	output logic commit,
	output logic taken
);

	typedef enum logic [1:0] {st_clear, st_idle, st_respond} state_t;

	state_t state;
	reg_addr_t reg_sel;
	logic accept; // access taken this cycle, ack follows
	logic [31:0] ip_lo;
	logic [1:0] pred_q; // {hit, taken}

	assign reg_sel = reg_addr_t'(adr);

	// while clearing only status gets through
	assign accept = cyc && stb && ((state == st_idle) ||
		(state == st_clear && (clear_done || reg_sel == reg_status)));

	assign lookup_ip = {dat_w, ip_lo}; // valid during the ip_hi write
	assign commit = accept && we && (reg_sel == reg_outcome);
	assign taken = dat_w[0];
	assign clear_en = !clear_done; // sweep keeps running through status reads

	// ############################################################
	// FSM and register effects
	// ############################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_clear;
			ack <= 1'b0;
			ip_lo <= '0;
			recent_ip <= '0;
			pred_q <= '0;
		end else begin
			ack <= accept; // one cycle, state leaves idle
			case (state)
				st_clear: begin
					if (accept) begin
						state <= st_respond;
					end else if (clear_done) begin
						state <= st_idle;
					end
				end
				st_idle: begin
					if (accept) begin
						state <= st_respond;
					end
				end
				default: begin
					// wait for the master to drop stb
					if (!stb) begin
						state <= clear_done ? st_idle : st_clear;
					end
				end
			endcase

			if (accept && we) begin
				case (reg_sel)
					reg_ip_lo: ip_lo <= dat_w;
					reg_ip_hi: begin
						recent_ip <= lookup_ip;
						pred_q <= {pred_hit, pred_taken};
					end
					default: ; // outcome goes out on commit
				endcase
			end
		end
	end

	// ############################################################
	// read data
	// ############################################################

	always_ff @(posedge clk) begin
		if (accept) begin
			if (we) begin
				dat_r <= '0;
			end else begin
				case (reg_sel)
					reg_pred: dat_r <= {30'd0, pred_q};
					reg_status: dat_r <= {31'd0, ~clear_done};
					default: dat_r <= '0; // unknown or write only
				endcase
			end
		end
	end

endmodule

//--- hdl/bp_pkg.sv
`include "bp_config.svh"

package bp_pkg;

	// table payloads
	typedef logic [`BP_TAG_BITS-1:0] tag_t;
	typedef logic [`BP_INDEX_BITS-1:0] index_t;

	// 2 bit saturating counter, upper bit is the direction
	typedef enum logic [1:0] {
		ctr_snt = 2'b00,
		ctr_wnt = 2'b01,
		ctr_wt = 2'b10,
		ctr_st = 2'b11
	} ctr_t;

	// bus word addresses
	typedef enum logic [`BP_WB_ADDR_BITS-1:0] {
		reg_ip_lo = 3'd0, // ip bits 31..0
		reg_ip_hi = 3'd1, // ip bits 63..32, starts lookup
		reg_pred = 3'd2, // {hit, taken}
		reg_outcome = 3'd3, // taken bit, starts update
		reg_status = 3'd4 // clearing bit
	} reg_addr_t;

endpackage

//--- hdl/bp_table.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_table import bp_pkg::*; #(
	parameter type payload_t = tag_t,
	parameter int depth = `BP_TABLE_SIZE
) (
	input logic clk,
	input logic we,
	input index_t waddr,
	input payload_t wdata,
	input index_t raddr_a,
	input index_t raddr_b,
	output payload_t rdata_a,
	output payload_t rdata_b
);

	// ############################################################
	// storage
	// ############################################################

	payload_t mem [depth];

	// single write port, used by both the sweep and the update
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// ############################################################
	// read ports
	// ############################################################

	// port a serves the lookup address
	assign rdata_a = mem[raddr_a];

	// port b serves the recent address
	assign rdata_b = mem[raddr_b];

endmodule

//--- hdl/bp_update.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_update import bp_pkg::*; (
	input logic [63:0] lookup_ip,
	input logic [63:0] recent_ip,
	input logic taken,
	input tag_t tag_lookup,
	input ctr_t ctr_lookup,
	input tag_t tag_recent,
	input ctr_t ctr_recent,
	output index_t lookup_index,
	output index_t recent_index,
	output logic pred_taken,
	output logic pred_hit,
	output tag_t next_tag,
	output ctr_t next_ctr
);

	tag_t lookup_tag;
	tag_t recent_tag;
	logic recent_hit;

	// address split
	assign lookup_tag = lookup_ip[63 -: `BP_TAG_BITS];
	assign lookup_index = lookup_ip[`BP_INDEX_BITS-1:0];
	assign recent_tag = recent_ip[63 -: `BP_TAG_BITS];
	assign recent_index = recent_ip[`BP_INDEX_BITS-1:0];

	// ############################################################
	// prediction
	// ############################################################

	assign pred_hit = (tag_lookup == lookup_tag);
	assign pred_taken = pred_hit && ctr_lookup[1]; // wt or st

	// ############################################################
	// next entry
	// ############################################################

	assign recent_hit = (tag_recent == recent_tag);
	assign next_tag = recent_tag; // same as stored on a hit

	always_comb begin
		if (!recent_hit) begin
			next_ctr = taken ? ctr_wt : ctr_wnt; // reallocate, weak state
		end else if (taken) begin
			next_ctr = (ctr_recent == ctr_st) ? ctr_st : ctr_t'(ctr_recent + 2'd1);
		end else begin
			next_ctr = (ctr_recent == ctr_snt) ? ctr_snt : ctr_t'(ctr_recent - 2'd1);
		end
	end

endmodule

//--- hdl/branch_predictor_top.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module branch_predictor_top import bp_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [`BP_WB_ADDR_BITS-1:0] adr,
	input logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic ack
);

	logic clear_en;
	logic clear_done;
	index_t clear_index;
	logic [63:0] lookup_ip;
	logic [63:0] recent_ip;
	logic commit;
	logic taken;
	logic pred_taken;
	logic pred_hit;
	index_t lookup_index;
	index_t recent_index;
	tag_t tag_lookup;
	tag_t tag_recent;
	ctr_t ctr_lookup;
	ctr_t ctr_recent;
	tag_t next_tag;
	ctr_t next_ctr;

	// ############################################################
	// write port select
	// ############################################################

	logic tbl_we;
	index_t tbl_waddr;
	tag_t tbl_wtag;
	ctr_t tbl_wctr;

	assign tbl_we = clear_en || commit;
	assign tbl_waddr = clear_en ? clear_index : recent_index;
	assign tbl_wtag = clear_en ? '0 : next_tag;
	assign tbl_wctr = clear_en ? ctr_t'(`BP_CTR_RESET) : next_ctr;

	bp_control bp_control_inst (
		.clk(clk), .rst(rst),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack),
		.clear_done(clear_done), .clear_en(clear_en),
		.pred_taken(pred_taken), .pred_hit(pred_hit),
		.lookup_ip(lookup_ip), .recent_ip(recent_ip),
		.commit(commit), .taken(taken)
	);

	bp_clear_counter bp_clear_counter_inst (
		.clk(clk), .rst(rst), .en(clear_en),
		.index(clear_index), .done(clear_done)
	);

	bp_update bp_update_inst (
		.lookup_ip(lookup_ip), .recent_ip(recent_ip), .taken(taken),
		.tag_lookup(tag_lookup), .ctr_lookup(ctr_lookup),
		.tag_recent(tag_recent), .ctr_recent(ctr_recent),
		.lookup_index(lookup_index), .recent_index(recent_index),
		.pred_taken(pred_taken), .pred_hit(pred_hit),
		.next_tag(next_tag), .next_ctr(next_ctr)
	);

	bp_table #(.payload_t(tag_t), .depth(`BP_TABLE_SIZE)) tag_table_inst (
		.clk(clk), .we(tbl_we), .waddr(tbl_waddr), .wdata(tbl_wtag),
		.raddr_a(lookup_index), .raddr_b(recent_index),
		.rdata_a(tag_lookup), .rdata_b(tag_recent)
	);

	bp_table #(.payload_t(ctr_t), .depth(`BP_TABLE_SIZE)) ctr_table_inst (
		.clk(clk), .we(tbl_we), .waddr(tbl_waddr), .wdata(tbl_wctr),
		.raddr_a(lookup_index), .raddr_b(recent_index),
		.rdata_a(ctr_lookup), .rdata_b(ctr_recent)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module branch_predictor_tb \
	-f branch_predictor_top.f \
	--Mdir obj_dir -o branch_predictor_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/branch_predictor_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation finished cleanly"
exit 0

//--- testbench/bp_golden.txt
# bus transactions for the branch predictor testbench, all values hex
# op (W write, R read and compare, P poll status) adr wdata expect name
R 4 00000000 00000001 status_clearing
P 4 00000000 00000000 status_done
W 0 00000010 00000000 zero_tag_lo
W 1 00000000 00000000 zero_tag_hi
R 2 00000000 00000003 zero_tag_hit
W 0 00000020 00000000 a_lo
W 1 00000001 00000000 a_hi
R 2 00000000 00000000 a_fresh_miss
W 3 00000001 00000000 a_taken
W 1 00000001 00000000 a_hi_again
R 2 00000000 00000003 a_realloc_taken
W 0 00000030 00000000 b_lo
W 1 00000002 00000000 b_hi
R 2 00000000 00000000 b_fresh_miss
W 3 00000000 00000000 b_not_taken
W 1 00000002 00000000 b_hi_again
R 2 00000000 00000002 b_realloc_not_taken
W 0 00000020 00000000 a_lo_sat
W 1 00000001 00000000 a_hi_sat
R 2 00000000 00000003 a_weak_taken
W 3 00000001 00000000 a_up_strong
W 3 00000001 00000000 a_up_saturate
W 3 00000000 00000000 a_down_one
W 1 00000001 00000000 a_hi_one
R 2 00000000 00000003 a_sat_one_nt
W 3 00000000 00000000 a_down_two
W 1 00000001 00000000 a_hi_two
R 2 00000000 00000002 a_sat_two_nt
W 0 00000030 00000000 b_lo_sat
W 1 00000002 00000000 b_hi_sat
R 2 00000000 00000002 b_weak_not_taken
W 3 00000000 00000000 b_down_strong
W 3 00000000 00000000 b_down_saturate
W 3 00000001 00000000 b_up_one
W 1 00000002 00000000 b_hi_one
R 2 00000000 00000002 b_sat_one_t
W 3 00000001 00000000 b_up_two
W 1 00000002 00000000 b_hi_two
R 2 00000000 00000003 b_sat_two_t
W 0 00000020 00000000 c_lo
W 1 00000003 00000000 c_hi
R 2 00000000 00000000 c_evict_miss
W 3 00000001 00000000 c_taken
W 1 00000001 00000000 a_hi_evicted
R 2 00000000 00000000 a_evicted_miss
W 1 00000003 00000000 c_hi_again
R 2 00000000 00000003 c_resident_hit
W 0 00000040 00000000 d_lo
W 1 00000004 00000000 d_hi
R 2 00000000 00000000 d_fresh_miss
W 3 00000001 00000000 d_taken_once
W 3 00000001 00000000 d_taken_twice
W 3 00000000 00000000 d_not_taken
W 1 00000004 00000000 d_hi_again
R 2 00000000 00000003 d_repeat_outcome
W 5 ffffffff 00000000 unknown_write
R 7 00000000 00000000 unknown_read
R 2 00000000 00000003 pred_held
R 4 00000000 00000000 status_after_sweep

//--- testbench/branch_predictor_assertions.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module branch_predictor_assertions import bp_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic [`BP_WB_ADDR_BITS-1:0] adr,
	input logic ack,
	input logic clear_done,
	input logic commit
);

	// ############################################################
	// bus handshake
	// ############################################################

	ack_needs_request: assert property (@(posedge clk) disable iff (rst)
		ack |-> $past(cyc && stb)) // ack is registered
		else $error("ack raised without cyc and stb in the cycle before");

	ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
		ack |=> !ack)
		else $error("ack held high for two cycles");

	// ############################################################
	// clear sweep
	// ############################################################

	status_only_while_clearing: assert property (@(posedge clk) disable iff (rst)
		(cyc && stb && !clear_done && adr != reg_status) |=> !ack)
		else $error("access other than status acknowledged during the clear sweep");

	no_commit_while_clearing: assert property (@(posedge clk) disable iff (rst)
		!clear_done |-> !commit)
		else $error("table update committed during the clear sweep");

endmodule

bind branch_predictor_top branch_predictor_assertions branch_predictor_assertions_inst (
	.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .adr(adr), .ack(ack),
	.clear_done(clear_done), .commit(commit)
);

//--- testbench/branch_predictor_tb.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module branch_predictor_tb;

	localparam string golden_path = "testbench/bp_golden.txt";
	localparam logic [`BP_WB_ADDR_BITS-1:0] outcome_adr = 3'd3; // reg_outcome

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [`BP_WB_ADDR_BITS-1:0] adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic ack;

	// transactions from the golden file
	logic [7:0] op_q [$];
	logic [`BP_WB_ADDR_BITS-1:0] adr_q [$];
	logic [31:0] wdata_q [$];
	logic [31:0] exp_q [$];
	logic [8*24-1:0] name_q [$];

	int cycles = 0;
	int cycle_limit = 0; // set once the file is loaded

	branch_predictor_top branch_predictor_top_inst (
		.clk(clk), .rst(rst),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack)
	);

	always #20 clk = ~clk; // 40 ns period

	// ############################################################
	// timeout
	// ############################################################

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: run went past %0d clock cycles", cycle_limit);
			$display("tests failed");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	// ############################################################
	// check and bus tasks
	// ############################################################

	task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %0s expected %08h actual %08h", name, expected, actual);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// one classic cycle, stb dropped right after ack is seen
	task automatic bus_access(input logic write, input logic [`BP_WB_ADDR_BITS-1:0] addr,
		input logic [31:0] wdata, input logic may_stall, output logic [31:0] rdata,
		output int waits);
		waits = 0;
		@(posedge clk);
		#2;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_w = wdata;
		@(posedge clk);
		#2;
		while (!ack) begin // back-pressure while clearing
			waits++;
			@(posedge clk);
			#2;
		end
		rdata = dat_r;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		if (!may_stall) begin
			check_value("ack_latency", 32'd0, waits); // ack on the next cycle
		end
	endtask

	task automatic wb_write(input logic [`BP_WB_ADDR_BITS-1:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		int waits;
		bus_access(1'b1, addr, data, 1'b0, unused, waits);
	endtask

	task automatic wb_read(input logic [`BP_WB_ADDR_BITS-1:0] addr, input logic [31:0] expected,
		input logic [8*24-1:0] name);
		logic [31:0] data;
		int waits;
		bus_access(1'b0, addr, 32'd0, 1'b0, data, waits);
		check_value(name, expected, data);
	endtask

	// outcome write issued mid sweep, must stall until clearing ends
	task automatic outcome_during_sweep();
		logic [31:0] unused;
		int waits;
		bus_access(1'b1, outcome_adr, 32'd0, 1'b1, unused, waits);
		check_value("ack_held_while_clearing", 32'd1, {31'd0, waits > 0});
	endtask

	// reads again while the clearing bit is set
	task automatic poll_status(input logic [`BP_WB_ADDR_BITS-1:0] addr,
		input logic [31:0] expected, input logic [8*24-1:0] name);
		logic [31:0] data;
		int waits;
		bus_access(1'b0, addr, 32'd0, 1'b0, data, waits);
		while (data == 32'd1) begin
			bus_access(1'b0, addr, 32'd0, 1'b0, data, waits);
		end
		check_value(name, expected, data);
	endtask

	task automatic load_golden();
		int fd;
		int n;
		string line;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] w;
		logic [31:0] e;
		logic [8*24-1:0] nm;
		fd = $fopen(golden_path, "r");
		if (fd == 0) begin
			$display("could not open the golden file %0s", golden_path);
			$display("tests failed");
			$fatal(1, "golden file missing");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0) begin
				n = $sscanf(line, "%s %h %h %h %s", op, a, w, e, nm);
				if (n == 5 && (op == "W" || op == "R" || op == "P")) begin // skips comments
					op_q.push_back(op);
					adr_q.push_back(a[`BP_WB_ADDR_BITS-1:0]);
					wdata_q.push_back(w);
					exp_q.push_back(e);
					name_q.push_back(nm);
				end
			end
		end
		$fclose(fd);
		if (op_q.size() == 0) begin
			$display("the golden file holds no transactions");
			$display("tests failed");
			$fatal(1, "empty golden file");
		end
	endtask

	// ############################################################
	// main sequence
	// ############################################################

	initial begin
		int i;
		clk = 1'b0;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		load_golden();
		cycle_limit = 256 + 8 * op_q.size() + 100; // sweep, transactions, margin
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		for (i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				"W": wb_write(adr_q[i], wdata_q[i]);
				"R": wb_read(adr_q[i], exp_q[i], name_q[i]);
				default: begin
					outcome_during_sweep();
					poll_status(adr_q[i], exp_q[i], name_q[i]);
				end
			endcase
		end
		$display("all tests passed");
		$finish;
	end

endmodule
